//--- mips_tlb.f
verilog/tlb_pkg.sv
verilog/tlb_search_if.sv
verilog/tlb_entry_array.sv
verilog/tlb_lookup.sv
verilog/tlb_fetch_xlate.sv
verilog/tlb_mem_xlate.sv
verilog/mips_tlb.sv
sim/tb_mips_tlb.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_mips_tlb -f mips_tlb.f \
    -o tb_mips_tlb && ./obj_dir/tb_mips_tlb | tee sim.log || echo "build or run failed"
grep -qsx "Regression passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

//--- sim/tb_mips_tlb.sv
`timescale 1ns/1ns
`default_nettype none

module tb_mips_tlb;
    import tlb_pkg::*;

    localparam int TLBNUM = 16;
    // roughly twelve times the length of the sequence below
    localparam int MAX_CYCLES = 2000;

    logic        clk;
    logic        resetn;
    logic [2:0]  i_k0;
    logic        i_we;
    logic        i_inst_en;
    logic        i_data_ren;
    logic        i_data_wen;
    logic        i_op_tlbp;
    logic [3:0]  i_w_index;
    logic [3:0]  i_r_index;
    logic [31:0] i_w_hi;
    logic [31:0] i_w_lo0;
    logic [31:0] i_w_lo1;
    logic [31:0] i_inst_vaddr;
    logic [31:0] i_data_vaddr;
    logic [31:0] o_r_hi;
    logic [31:0] o_r_lo0;
    logic [31:0] o_r_lo1;
    logic [31:0] o_p_index;
    logic [19:0] o_inst_tag;
    logic [19:0] o_data_tag;
    logic        o_inst_uncached;
    logic        o_data_uncached;
    logic        o_i_refill;
    logic        o_i_invalid;
    logic        o_d_refill;
    logic        o_d_invalid;
    logic        o_d_modify;

    tlb_entry_t  shadow [TLBNUM];
    tlb_entry_t  ent;
    logic        g0;
    logic        g1;
    logic [31:0] r;
    logic [31:0] va;
    integer      seed;
    int          errors;
    int          checks;
    int          cycle_count;

    mips_tlb #(.TLBNUM(TLBNUM)) i_mips_tlb (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < MAX_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
        $display("Regression failed");
        $finish;
    end

    function automatic logic [31:0] hi_image(input tlb_entry_t e);
        return {e.vpn2, 5'b0, e.asid};
    endfunction

    function automatic logic [31:0] lo_image(input tlb_page_t p, input logic g);
        return {6'b0, p.pfn, p.c, p.d, p.v, g};
    endfunction

    // first shadow entry with the same vpn2 and a matching or global asid
    function automatic int lowest_match(input logic [18:0] vpn2, input logic [7:0] asid);
        int hit;
        hit = -1;
        for (int i = 0; i < TLBNUM; i++) begin
            if (hit < 0 && shadow[i].vpn2 == vpn2 &&
                (shadow[i].asid == asid || shadow[i].g)) begin
                hit = i;
            end
        end
        return hit;
    endfunction

    task automatic check_equal(input string test, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("[ERROR] %s %s: expected 0x%0h, actual 0x%0h",
                     test, what, expected, actual);
        end
    endtask

    // vpn2 kept out of kseg0/kseg1
    task automatic random_entry(output tlb_entry_t e, output logic ga, output logic gb);
        logic [31:0] ra;
        logic [31:0] rb;
        logic [31:0] rc;
        ra = $random(seed);
        rb = $random(seed);
        rc = $random(seed);
        e.vpn2 = ra[18:0];
        if (ra[18:17] == 2'b10) begin
            e.vpn2[18] = 1'b0;
        end
        e.asid  = ra[26:19];
        e.g     = 1'b0;
        ga      = ra[27];
        gb      = ra[28];
        e.page0 = '{pfn: rb[19:0], c: rb[22:20], d: rb[23], v: rb[24]};
        e.page1 = '{pfn: rc[19:0], c: rc[22:20], d: rc[23], v: rc[24]};
    endtask

    // read port aimed at the written index shows the bypass
    task automatic write_entry(input string test, input int idx, input tlb_entry_t e,
                               input logic ga, input logic gb);
        tlb_entry_t m;
        m   = e;
        m.g = ga & gb;
        @(posedge clk);
        i_we      <= 1'b1;
        i_w_index <= 4'(idx);
        i_r_index <= 4'(idx);
        i_w_hi    <= hi_image(e);
        i_w_lo0   <= lo_image(e.page0, ga);
        i_w_lo1   <= lo_image(e.page1, gb);
        @(negedge clk);
        check_equal(test, "bypass hi", hi_image(m), o_r_hi);
        check_equal(test, "bypass lo0", lo_image(m.page0, m.g), o_r_lo0);
        check_equal(test, "bypass lo1", lo_image(m.page1, m.g), o_r_lo1);
        shadow[idx] = m;
    endtask

    task automatic read_entry(input string test, input int idx);
        @(posedge clk);
        i_we      <= 1'b0;
        i_r_index <= 4'(idx);
        @(negedge clk);
        check_equal(test, "hi", hi_image(shadow[idx]), o_r_hi);
        check_equal(test, "lo0", lo_image(shadow[idx].page0, shadow[idx].g), o_r_lo0);
        check_equal(test, "lo1", lo_image(shadow[idx].page1, shadow[idx].g), o_r_lo1);
    endtask

    // same address on fetch and data side with a store when wen is set
    task automatic access(input string test, input logic [31:0] addr, input logic [7:0] asid,
                          input logic en, input logic wen);
        int          hit;
        tlb_page_t   pg;
        logic [2:0]  seg;
        logic        unmapped;
        logic [19:0] exp_tag;
        logic        exp_unc;
        logic        refill;
        logic        invalid;
        logic        modify;
        @(posedge clk);
        i_we         <= 1'b0;
        i_op_tlbp    <= 1'b0;
        i_w_hi       <= {24'h0, asid};
        i_inst_vaddr <= addr;
        i_data_vaddr <= addr;
        i_inst_en    <= en;
        i_data_ren   <= en & ~wen;
        i_data_wen   <= en & wen;
        @(negedge clk);
        seg      = addr[31:29];
        unmapped = (seg == 3'b100) || (seg == 3'b101);
        hit      = lowest_match(addr[31:13], asid);
        pg       = '0;
        if (hit >= 0) begin
            pg = addr[12] ? shadow[hit].page1 : shadow[hit].page0;
        end
        exp_tag = unmapped ? {3'b0, addr[28:12]} : pg.pfn;
        exp_unc = (seg == 3'b101) || (seg == 3'b100 && i_k0 != 3'd3) ||
                  (!unmapped && pg.c != 3'd3);
        refill  = en && !unmapped && hit < 0;
        invalid = en && !unmapped && hit >= 0 && !pg.v;
        modify  = en && wen && !unmapped && hit >= 0 && pg.v && !pg.d;
        check_equal(test, "inst tag", 32'(exp_tag), 32'(o_inst_tag));
        check_equal(test, "data tag", 32'(exp_tag), 32'(o_data_tag));
        check_equal(test, "inst uncached", 32'(exp_unc), 32'(o_inst_uncached));
        check_equal(test, "data uncached", 32'(exp_unc), 32'(o_data_uncached));
        // i_refill, i_invalid, d_refill, d_invalid, d_modify
        check_equal(test, "exceptions", {27'b0, refill, invalid, refill, invalid, modify},
                    {27'b0, o_i_refill, o_i_invalid, o_d_refill, o_d_invalid, o_d_modify});
    endtask

    task automatic probe(input string test, input logic [18:0] vpn2, input logic [7:0] asid);
        int hit;
        @(posedge clk);
        i_we      <= 1'b0;
        i_op_tlbp <= 1'b1;
        i_w_hi    <= {vpn2, 5'b0, asid};
        @(negedge clk);
        hit = lowest_match(vpn2, asid);
        check_equal(test, "index", (hit < 0) ? 32'h8000_0000 : 32'(hit), o_p_index);
    endtask

    initial begin
        seed         = 32'h2a39_17a3;
        errors       = 0;
        checks       = 0;
        resetn       <= 1'b0;
        i_k0         <= 3'd3;
        i_we         <= 1'b0;
        i_inst_en    <= 1'b0;
        i_data_ren   <= 1'b0;
        i_data_wen   <= 1'b0;
        i_op_tlbp    <= 1'b0;
        i_w_index    <= '0;
        i_r_index    <= '0;
        i_w_hi       <= '0;
        i_w_lo0      <= '0;
        i_w_lo1      <= '0;
        i_inst_vaddr <= '0;
        i_data_vaddr <= '0;
        for (int i = 0; i < TLBNUM; i++) begin
            shadow[i] = '0;
        end
        repeat (16) @(posedge clk);
        resetn <= 1'b1;

        access("idle_after_reset", 32'h0040_0000, 8'h00, 1'b0, 1'b0);

        for (int i = 0; i < TLBNUM; i++) begin
            random_entry(ent, g0, g1);
            write_entry("write_all", i, ent, g0, g1);
        end
        for (int i = 0; i < TLBNUM; i++) begin
            read_entry("read_back", i);
        end

        // both pages of every entry, load then store
        for (int i = 0; i < TLBNUM; i++) begin
            for (int p = 0; p < 2; p++) begin
                r  = $random(seed);
                va = {shadow[i].vpn2, p[0], r[11:0]};
                access("mapped_load", va, shadow[i].asid, 1'b1, 1'b0);
                access("mapped_store", va, shadow[i].asid, 1'b1, 1'b1);
            end
        end

        // global kseg2 entry hits under a foreign asid
        ent = '{vpn2: 19'h60123, asid: 8'h11, g: 1'b0,
                page0: '{pfn: 20'h0a5a5, c: 3'd3, d: 1'b1, v: 1'b1},
                page1: '{pfn: 20'h05a5a, c: 3'd2, d: 1'b1, v: 1'b1}};
        write_entry("write_global", 4, ent, 1'b1, 1'b1);
        access("global_even", 32'hc024_6010, 8'h22, 1'b1, 1'b1);
        access("global_odd", 32'hc024_7ffc, 8'h22, 1'b1, 1'b0);
        ent.vpn2 = 19'h60124;
        write_entry("write_private", 5, ent, 1'b1, 1'b0);
        access("asid_mismatch", 32'hc024_8000, 8'h22, 1'b1, 1'b0);
        access("asid_match", 32'hc024_8000, 8'h11, 1'b1, 1'b0);

        // invalid entry aliasing kseg0 must not matter
        ent.vpn2    = 19'h40000;
        ent.page0.v = 1'b0;
        write_entry("write_kseg0_alias", 6, ent, 1'b1, 1'b1);
        access("kseg0_alias", 32'h8000_0123, 8'h11, 1'b1, 1'b1);
        for (int k = 0; k < 2; k++) begin
            @(posedge clk);
            i_we <= 1'b0;
            i_k0 <= (k == 0) ? 3'd3 : 3'd2;
            for (int n = 0; n < 4; n++) begin
                r = $random(seed);
                access("kseg0", {3'b100, r[28:0]}, 8'h00, 1'b1, r[29]);
                access("kseg1", {3'b101, r[28:0]}, 8'h00, 1'b1, r[29]);
            end
        end

        ent = '{vpn2: 19'h00abc, asid: 8'h5a, g: 1'b0,
                page0: '{pfn: 20'h11111, c: 3'd3, d: 1'b1, v: 1'b0},
                page1: '{pfn: 20'h22222, c: 3'd3, d: 1'b0, v: 1'b1}};
        write_entry("write_exc", 3, ent, 1'b0, 1'b0);
        access("invalid_load", 32'h0157_8040, 8'h5a, 1'b1, 1'b0);
        access("invalid_store", 32'h0157_8ff0, 8'h5a, 1'b1, 1'b1);
        access("modify_store", 32'h0157_9004, 8'h5a, 1'b1, 1'b1);
        access("clean_load", 32'h0157_9004, 8'h5a, 1'b1, 1'b0);
        access("refill", 32'h0157_a000, 8'h5a, 1'b1, 1'b0);
        access("enables_off", 32'h0157_9004, 8'h5a, 1'b0, 1'b1);
        access("enables_off_miss", 32'h0157_a000, 8'h5a, 1'b0, 1'b0);
        access("enables_off_invalid", 32'h0157_8040, 8'h5a, 1'b0, 1'b0);

        for (int i = 0; i < TLBNUM; i++) begin
            probe("probe_hit", shadow[i].vpn2, shadow[i].asid);
        end
        probe("probe_miss", 19'h5abcd, 8'h5a);
        ent.vpn2 = 19'h1f00f;
        ent.asid = 8'h77;
        write_entry("write_dup_low", 9, ent, 1'b0, 1'b0);
        write_entry("write_dup_high", 12, ent, 1'b1, 1'b1);
        probe("probe_dup", 19'h1f00f, 8'h77);
        probe("probe_dup_global", 19'h1f00f, 8'h78);

        @(posedge clk);
        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/mips_tlb.sv
`timescale 1ns/1ns
`default_nettype none

module mips_tlb #(
    parameter int TLBNUM = 16
) (
    input  logic                        clk,
    input  logic                        resetn,
    input  logic [tlb_pkg::CACHE_W-1:0] i_k0,

    // write port
    input  logic                        i_we,
    input  logic [$clog2(TLBNUM)-1:0]   i_w_index,
    input  logic [31:0]                 i_w_hi,
    input  logic [31:0]                 i_w_lo0,
    input  logic [31:0]                 i_w_lo1,

    // read port
    input  logic [$clog2(TLBNUM)-1:0]   i_r_index,
    output logic [31:0]                 o_r_hi,
    output logic [31:0]                 o_r_lo0,
    output logic [31:0]                 o_r_lo1,

    // instruction side
    input  logic                        i_inst_en,
    input  logic [31:0]                 i_inst_vaddr,
    output logic [tlb_pkg::PFN_W-1:0]   o_inst_tag,
    output logic                        o_inst_uncached,

    // data side
    input  logic                        i_data_ren,
    input  logic                        i_data_wen,
    input  logic [31:0]                 i_data_vaddr,
    output logic [tlb_pkg::PFN_W-1:0]   o_data_tag,
    output logic                        o_data_uncached,

    // probe
    input  logic                        i_op_tlbp,
    output logic [31:0]                 o_p_index,

    // exceptions
    output logic                        o_i_refill,
    output logic                        o_i_invalid,
    output logic                        o_d_refill,
    output logic                        o_d_invalid,
    output logic                        o_d_modify
);
    import tlb_pkg::*;

    tlb_entry_t entries [TLBNUM];

    tlb_search_if #(.TLBNUM(TLBNUM)) inst_search ();
    tlb_search_if #(.TLBNUM(TLBNUM)) data_search ();

    tlb_entry_array #(
        .TLBNUM(TLBNUM)
    ) u_entry_array (
        .clk       (clk),
        .resetn    (resetn),
        .i_we      (i_we),
        .i_w_index (i_w_index),
        .i_w_hi    (i_w_hi),
        .i_w_lo0   (i_w_lo0),
        .i_w_lo1   (i_w_lo1),
        .i_r_index (i_r_index),
        .o_entries (entries),
        .o_r_hi    (o_r_hi),
        .o_r_lo0   (o_r_lo0),
        .o_r_lo1   (o_r_lo1)
    );

    tlb_lookup #(
        .TLBNUM(TLBNUM)
    ) u_inst_lookup (
        .i_entries (entries),
        .search    (inst_search.lookup)
    );

    tlb_lookup #(
        .TLBNUM(TLBNUM)
    ) u_data_lookup (
        .i_entries (entries),
        .search    (data_search.lookup)
    );

    // current asid lives in EntryHi
    tlb_fetch_xlate u_fetch_xlate (
        .i_k0            (i_k0),
        .i_inst_en       (i_inst_en),
        .i_inst_vaddr    (i_inst_vaddr),
        .i_cur_asid      (i_w_hi[ASID_W-1:0]),
        .o_inst_tag      (o_inst_tag),
        .o_inst_uncached (o_inst_uncached),
        .o_i_refill      (o_i_refill),
        .o_i_invalid     (o_i_invalid),
        .search          (inst_search.requester)
    );

    tlb_mem_xlate u_mem_xlate (
        .i_k0            (i_k0),
        .i_data_ren      (i_data_ren),
        .i_data_wen      (i_data_wen),
        .i_data_vaddr    (i_data_vaddr),
        .i_w_hi          (i_w_hi),
        .i_op_tlbp       (i_op_tlbp),
        .o_data_tag      (o_data_tag),
        .o_data_uncached (o_data_uncached),
        .o_p_index       (o_p_index),
        .o_d_refill      (o_d_refill),
        .o_d_invalid     (o_d_invalid),
        .o_d_modify      (o_d_modify),
        .search          (data_search.requester)
    );

endmodule

`default_nettype wire

//--- verilog/tlb_mem_xlate.sv
`timescale 1ns/1ns
`default_nettype none

module tlb_mem_xlate (
    input  logic [tlb_pkg::CACHE_W-1:0] i_k0,
    input  logic                        i_data_ren,
    input  logic                        i_data_wen,
    input  logic [31:0]                 i_data_vaddr,
    input  logic [31:0]                 i_w_hi,
    input  logic                        i_op_tlbp,
    output logic [tlb_pkg::PFN_W-1:0]   o_data_tag,
    output logic                        o_data_uncached,
    output logic [31:0]                 o_p_index,
    output logic                        o_d_refill,
    output logic                        o_d_invalid,
    output logic                        o_d_modify,
    tlb_search_if.requester             search
);
    import tlb_pkg::*;

    logic unmapped;
    logic kseg1;
    logic kseg0;
    logic access;
    logic mapped_hit;

    // tlbp borrows the data port and searches with EntryHi
    assign search.vpn2     = i_op_tlbp ? i_w_hi[31:13] : i_data_vaddr[31:13];
    assign search.odd_page = i_op_tlbp ? i_w_hi[12]    : i_data_vaddr[12];
    assign search.asid     = i_w_hi[ASID_W-1:0];

    assign unmapped = seg_unmapped(i_data_vaddr);
    assign kseg1    = seg_uncached_kseg1(i_data_vaddr);
    assign kseg0    = unmapped & ~kseg1;

    assign o_data_tag = unmapped ? {3'b0, i_data_vaddr[28:12]} : search.pfn;

    assign o_data_uncached = kseg1
                           | (kseg0 & (i_k0 != CACHEABLE))
                           | (~unmapped & (search.c != CACHEABLE));

    assign access     = i_data_ren | i_data_wen;
    assign mapped_hit = ~unmapped & search.found;

    assign o_d_refill  = access & ~unmapped & ~search.found;
    assign o_d_invalid = access & mapped_hit & ~search.v;
    // store to a clean valid page
    assign o_d_modify  = i_data_wen & mapped_hit & search.v & ~search.d;

    assign o_p_index = search.found ? 32'(search.index) : PROBE_MISS;

endmodule

`default_nettype wire

//--- verilog/tlb_fetch_xlate.sv
`timescale 1ns/1ns
`default_nettype none

module tlb_fetch_xlate (
    input  logic [tlb_pkg::CACHE_W-1:0] i_k0,
    input  logic                        i_inst_en,
    input  logic [31:0]                 i_inst_vaddr,
    input  logic [tlb_pkg::ASID_W-1:0]  i_cur_asid,
    output logic [tlb_pkg::PFN_W-1:0]   o_inst_tag,
    output logic                        o_inst_uncached,
    output logic                        o_i_refill,
    output logic                        o_i_invalid,
    tlb_search_if.requester             search
);
    import tlb_pkg::*;

    logic unmapped;
    logic kseg1;
    logic kseg0;

    assign search.vpn2     = i_inst_vaddr[31:13];
    assign search.odd_page = i_inst_vaddr[12];
    assign search.asid     = i_cur_asid;

    assign unmapped = seg_unmapped(i_inst_vaddr);
    assign kseg1    = seg_uncached_kseg1(i_inst_vaddr);
    assign kseg0    = unmapped & ~kseg1;

    // unmapped segments strip the top three bits
    assign o_inst_tag = unmapped ? {3'b0, i_inst_vaddr[28:12]} : search.pfn;

    assign o_inst_uncached = kseg1
                           | (kseg0 & (i_k0 != CACHEABLE))
                           | (~unmapped & (search.c != CACHEABLE));

    assign o_i_refill  = i_inst_en & ~unmapped & ~search.found;
    assign o_i_invalid = i_inst_en & ~unmapped & search.found & ~search.v;

endmodule

`default_nettype wire

//--- verilog/tlb_lookup.sv
`timescale 1ns/1ns
`default_nettype none

module tlb_lookup #(
    parameter int TLBNUM = 16
) (
    input  tlb_pkg::tlb_entry_t i_entries [TLBNUM],
    tlb_search_if.lookup        search
);
    import tlb_pkg::*;

    localparam int IDX_W = $clog2(TLBNUM);

    logic [TLBNUM-1:0] match;
    logic              hit;
    logic [IDX_W-1:0]  hit_idx;
    tlb_page_t         sel_page;

    always_comb begin
        for (int i = 0; i < TLBNUM; i++) begin
            match[i] = (i_entries[i].vpn2 == search.vpn2) &&
                       ((i_entries[i].asid == search.asid) || i_entries[i].g);
        end
    end

    assign hit = |match;

    // lowest index wins
    always_comb begin
        hit_idx = '0;
        for (int i = TLBNUM - 1; i >= 0; i--) begin
            if (match[i]) begin
                hit_idx = IDX_W'(i);
            end
        end
    end

    // even/odd page of the winner or zero on a miss
    always_comb begin
        if (!hit) begin
            sel_page = '0;
        end else if (search.odd_page) begin
            sel_page = i_entries[hit_idx].page1;
        end else begin
            sel_page = i_entries[hit_idx].page0;
        end
    end

    assign search.found = hit;
    assign search.index = hit_idx;
    assign search.pfn   = sel_page.pfn;
    assign search.c     = sel_page.c;
    assign search.d     = sel_page.d;
    assign search.v     = sel_page.v;

endmodule

`default_nettype wire

//--- verilog/tlb_entry_array.sv
`timescale 1ns/1ns
`default_nettype none

module tlb_entry_array #(
    parameter int TLBNUM = 16
) (
    input  logic                      clk,
    input  logic                      resetn,
    input  logic                      i_we,
    input  logic [$clog2(TLBNUM)-1:0] i_w_index,
    input  logic [31:0]               i_w_hi,
    input  logic [31:0]               i_w_lo0,
    input  logic [31:0]               i_w_lo1,
    input  logic [$clog2(TLBNUM)-1:0] i_r_index,
    output tlb_pkg::tlb_entry_t       o_entries [TLBNUM],
    output logic [31:0]               o_r_hi,
    output logic [31:0]               o_r_lo0,
    output logic [31:0]               o_r_lo1
);
    import tlb_pkg::*;

    tlb_entry_t entries [TLBNUM];
    tlb_entry_t w_entry;
    tlb_entry_t r_entry;

    // unpack register images
    always_comb begin
        w_entry.vpn2       = i_w_hi[31:13];
        w_entry.asid       = i_w_hi[7:0];
        w_entry.g          = i_w_lo0[0] & i_w_lo1[0];
        w_entry.page0.pfn  = i_w_lo0[25:6];
        w_entry.page0.c    = i_w_lo0[5:3];
        w_entry.page0.d    = i_w_lo0[2];
        w_entry.page0.v    = i_w_lo0[1];
        w_entry.page1.pfn  = i_w_lo1[25:6];
        w_entry.page1.c    = i_w_lo1[5:3];
        w_entry.page1.d    = i_w_lo1[2];
        w_entry.page1.v    = i_w_lo1[1];
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int k = 0; k < TLBNUM; k++) begin
                entries[k] <= '0;
            end
        end else if (i_we) begin
            entries[i_w_index] <= w_entry;
        end
    end

    assign o_entries = entries;

    // read sees a same-cycle write to its index
    assign r_entry = (i_we && (i_r_index == i_w_index)) ? w_entry : entries[i_r_index];

    assign o_r_hi  = {r_entry.vpn2, 5'b0, r_entry.asid};
    assign o_r_lo0 = {6'b0, r_entry.page0.pfn, r_entry.page0.c,
                      r_entry.page0.d, r_entry.page0.v, r_entry.g};
    assign o_r_lo1 = {6'b0, r_entry.page1.pfn, r_entry.page1.c,
                      r_entry.page1.d, r_entry.page1.v, r_entry.g};

endmodule

`default_nettype wire

//--- verilog/tlb_search_if.sv
`timescale 1ns/1ns
`default_nettype none

interface tlb_search_if #(
    parameter int TLBNUM = 16
);
    import tlb_pkg::*;

    // query
    logic [VPN2_W-1:0]         vpn2;
    logic                      odd_page;
    logic [ASID_W-1:0]         asid;

    // result is valid in the same cycle
    logic                      found;
    logic [$clog2(TLBNUM)-1:0] index;
    logic [PFN_W-1:0]          pfn;
    logic [CACHE_W-1:0]        c;
    logic                      d;
    logic                      v;

    modport requester (
        output vpn2, odd_page, asid,
        input  found, index, pfn, c, d, v
    );

    modport lookup (
        input  vpn2, odd_page, asid,
        output found, index, pfn, c, d, v
    );

endinterface

`default_nettype wire

//--- verilog/tlb_pkg.sv
`default_nettype none

package tlb_pkg;

    // field widths
    localparam int VPN2_W  = 19;
    localparam int ASID_W  = 8;
    localparam int PFN_W   = 20;
    localparam int CACHE_W = 3;

    // cache attribute code for cached noncoherent
    localparam logic [CACHE_W-1:0] CACHEABLE = 3'd3;

    // probe result on a miss has only the P bit set
    localparam logic [31:0] PROBE_MISS = 32'h8000_0000;

    // one page of an even/odd pair
    typedef struct packed {
        logic [PFN_W-1:0]   pfn;
        logic [CACHE_W-1:0] c;
        logic               d;
        logic               v;
    } tlb_page_t;

    // one joint tlb entry with g merged from both EntryLo G bits
    typedef struct packed {
        logic [VPN2_W-1:0] vpn2;
        logic [ASID_W-1:0] asid;
        logic              g;
        tlb_page_t         page0;
        tlb_page_t         page1;
    } tlb_entry_t;

    // kseg0 or kseg1
    function automatic logic seg_unmapped(input logic [31:0] vaddr);
        logic [2:0] seg;
        seg = vaddr[31:29];
        return (seg == 3'b100) || (seg == 3'b101);
    endfunction

    // kseg1 only
    function automatic logic seg_uncached_kseg1(input logic [31:0] vaddr);
        return vaddr[31:29] == 3'b101;
    endfunction

endpackage

`default_nettype wire
